// File: hdl/exe_bus_if.sv
`timescale 1ns/1ps

interface exe_bus_if import exe_pkg::*; #(
    parameter int DATA_W = 32
) ();

    res_kind_e         kind;
    logic [REG_AW-1:0] rd;
    logic [DATA_W-1:0] result;
    logic              mul_high;
    logic              mul_unsigned;
    // half x half products, already extended to full width
    logic [DATA_W-1:0] pp0;
    logic [DATA_W-1:0] pp1;
    logic [DATA_W-1:0] pp2;
    logic [DATA_W-1:0] pp3;

    modport src (
        output kind, rd, result, mul_high, mul_unsigned, pp0, pp1, pp2, pp3
    );

    modport sink (
        input kind, rd, result, mul_high, mul_unsigned, pp0, pp1, pp2, pp3
    );

    // forwarding and hazard view
    modport snoop (
        input kind, rd, result
    );

endinterface

// File: hdl/exe_issue.sv
`timescale 1ns/1ps

module exe_issue import uop_pkg::*, exe_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  logic              in_valid,
    input  uop_t              uop,
    input  logic [REG_AW-1:0] rd,
    input  logic [REG_AW-1:0] rj,
    input  logic [REG_AW-1:0] rk,
    input  logic [DATA_W-1:0] rf_data0,
    input  logic [DATA_W-1:0] rf_data1,
    input  logic [DATA_W-1:0] imm,
    input  logic [DATA_W-1:0] pc,
    input  logic [DATA_W-1:0] pc_next,
    exe_bus_if.snoop          s1,
    input  logic              wb_en,
    input  logic [REG_AW-1:0] wb_rd,
    input  logic [DATA_W-1:0] wb_data,
    exe_bus_if.src            s0,
    output logic              hazard,
    output logic              br_valid,
    output logic              br_taken,
    output logic              br_mispredict,
    output logic [DATA_W-1:0] br_target
);

    localparam int H = DATA_W / 2;
    localparam int SHW = $clog2(DATA_W);

    logic              is_br;
    logic              is_link;
    logic              uses_j;
    logic              uses_k;
    logic [DATA_W-1:0] src_j;
    logic [DATA_W-1:0] src_k;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] alu_res;
    logic [DATA_W-1:0] seq_pc;
    logic              cond_hit;
    logic              sx;
    logic [DATA_W-1:0] a_hi;
    logic [DATA_W-1:0] a_lo;
    logic [DATA_W-1:0] b_hi;
    logic [DATA_W-1:0] b_lo;

    // newest value wins and r0 is never forwarded
    assign src_j = (rj != '0 && s1.kind == RES_FINAL && s1.rd == rj) ? s1.result :
                   (rj != '0 && wb_en && wb_rd == rj)                ? wb_data   :
                                                                       rf_data0;
    assign src_k = (rk != '0 && s1.kind == RES_FINAL && s1.rd == rk) ? s1.result :
                   (rk != '0 && wb_en && wb_rd == rk)                ? wb_data   :
                                                                       rf_data1;

    assign is_br = uop.cls == UOP_BR;
    assign is_link = is_br && (uop.br_cond == BR_BL || uop.br_cond == BR_JIRL);

    // only real source operands can hit a pending multiply
    assign uses_j = !(is_br && (uop.br_cond == BR_B || uop.br_cond == BR_BL));
    assign uses_k = (uop.cls == UOP_ALU) ? !uop.use_imm :
                    is_br ? !(uop.br_cond inside {BR_B, BR_BL, BR_JIRL}) : 1'b1;

    assign hazard = in_valid && s1.kind == RES_MUL_PART && s1.rd != '0 &&
                    ((uses_j && s1.rd == rj) || (uses_k && s1.rd == rk));

    assign op_b = uop.use_imm ? imm : src_k;

    always_comb begin
        case (uop.alu_op)
            ALU_ADD:  alu_res = src_j + op_b;
            ALU_SUB:  alu_res = src_j - op_b;
            ALU_AND:  alu_res = src_j & op_b;
            ALU_OR:   alu_res = src_j | op_b;
            ALU_XOR:  alu_res = src_j ^ op_b;
            ALU_SLL:  alu_res = src_j << op_b[SHW-1:0];
            ALU_SRL:  alu_res = src_j >> op_b[SHW-1:0];
            ALU_SRA:  alu_res = $signed(src_j) >>> op_b[SHW-1:0];
            ALU_SLT:  alu_res = {{(DATA_W-1){1'b0}}, $signed(src_j) < $signed(op_b)};
            ALU_SLTU: alu_res = {{(DATA_W-1){1'b0}}, src_j < op_b};
            default:  alu_res = '0;
        endcase
    end

    always_comb begin
        case (uop.br_cond)
            BR_JIRL, BR_B, BR_BL: cond_hit = 1'b1;
            BR_BEQ:  cond_hit = src_j == src_k;
            BR_BNE:  cond_hit = src_j != src_k;
            BR_BLT:  cond_hit = $signed(src_j) < $signed(src_k);
            BR_BGE:  cond_hit = $signed(src_j) >= $signed(src_k);
            BR_BLTU: cond_hit = src_j < src_k;
            BR_BGEU: cond_hit = src_j >= src_k;
            default: cond_hit = 1'b0;
        endcase
    end

    assign seq_pc = pc + DATA_W'(4);
    assign br_target = (uop.br_cond == BR_JIRL) ? src_j + imm : pc + imm;
    assign br_valid = in_valid && is_br && !hazard;
    assign br_taken = br_valid && cond_hit;
    // predictor was right only if pc_next equals the resolved path
    assign br_mispredict = br_valid && ((cond_hit ? br_target : seq_pc) != pc_next);

    // high operand halves keep the sign for signed products
    assign sx = !uop.mul_unsigned;
    assign a_hi = {{H{sx & src_j[DATA_W-1]}}, src_j[DATA_W-1:H]};
    assign a_lo = {{H{1'b0}}, src_j[H-1:0]};
    assign b_hi = {{H{sx & src_k[DATA_W-1]}}, src_k[DATA_W-1:H]};
    assign b_lo = {{H{1'b0}}, src_k[H-1:0]};

    assign s0.pp0 = a_lo * b_lo;
    assign s0.pp1 = a_lo * b_hi;
    assign s0.pp2 = a_hi * b_lo;
    assign s0.pp3 = a_hi * b_hi;
    assign s0.mul_high = uop.mul_high;
    assign s0.mul_unsigned = uop.mul_unsigned;
    assign s0.rd = rd;
    assign s0.result = is_br ? seq_pc : alu_res;

    always_comb begin
        s0.kind = RES_NONE;
        if (in_valid && !hazard) begin
            case (uop.cls)
                UOP_ALU: s0.kind = RES_FINAL;
                UOP_MUL: s0.kind = RES_MUL_PART;
                UOP_BR:  s0.kind = is_link ? RES_FINAL : RES_NONE;
                default: s0.kind = RES_NONE;
            endcase
        end
    end

    // an unknown code would silently resolve as not taken
    always_comb begin
        if (br_valid) begin
            assert (uop.br_cond inside {BR_JIRL, BR_B, BR_BL, BR_BEQ, BR_BNE, BR_BLT, BR_BGE,
                                        BR_BLTU, BR_BGEU})
                else $error("branch uop with an unknown condition code");
        end
    end

endmodule

// File: hdl/exe_pkg.sv
package exe_pkg;

    // architectural register index, r0 hardwired to zero
    localparam int REG_AW = 5;

    // what a stage register slot holds
    typedef enum logic [1:0] {
        RES_NONE     = 2'd0,
        RES_FINAL    = 2'd1,
        RES_MUL_PART = 2'd2
    } res_kind_e;

endpackage

// File: hdl/exe_retire.sv
`timescale 1ns/1ps

module exe_retire import exe_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  logic              clk,
    input  logic              rstn,
    exe_bus_if.sink           s1,
    input  logic              wb_ready,
    output logic              wb_en,
    output logic [REG_AW-1:0] wb_rd,
    output logic [DATA_W-1:0] wb_data
);

    localparam int H = DATA_W / 2;

    logic                sx;
    logic [2*DATA_W-1:0] ext0;
    logic [2*DATA_W-1:0] ext1;
    logic [2*DATA_W-1:0] ext2;
    logic [2*DATA_W-1:0] ext3;
    logic [2*DATA_W-1:0] product;
    logic [DATA_W-1:0]   mul_word;
    logic [DATA_W-1:0]   result;
    logic                wr;

    // lo x lo is always unsigned while the rest carry the operand sign
    assign sx = !s1.mul_unsigned;
    assign ext0 = {{DATA_W{1'b0}}, s1.pp0};
    assign ext1 = {{DATA_W{sx & s1.pp1[DATA_W-1]}}, s1.pp1};
    assign ext2 = {{DATA_W{sx & s1.pp2[DATA_W-1]}}, s1.pp2};
    assign ext3 = {{DATA_W{sx & s1.pp3[DATA_W-1]}}, s1.pp3};

    assign product = ext0 + (ext1 << H) + (ext2 << H) + (ext3 << DATA_W);
    assign mul_word = s1.mul_high ? product[2*DATA_W-1:DATA_W] : product[DATA_W-1:0];

    assign result = (s1.kind == RES_MUL_PART) ? mul_word : s1.result;
    assign wr = s1.kind != RES_NONE && s1.rd != '0;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb_en <= 1'b0;
            wb_rd <= '0;
        end else if (wb_ready) begin
            wb_en <= wr;
            wb_rd <= s1.rd;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_ready) begin
            wb_data <= result;
        end
    end

    // a slot under back-pressure must wait here unchanged
    assert property (@(posedge clk) disable iff (!rstn)
        !wb_ready |=> $stable(s1.kind) && $stable(s1.rd) && $stable(s1.result) &&
                      $stable(s1.mul_high) && $stable(s1.mul_unsigned) &&
                      $stable(s1.pp0) && $stable(s1.pp1) && $stable(s1.pp2) &&
                      $stable(s1.pp3))
        else $error("incoming slot changed while wb_ready was low");

endmodule

// File: hdl/exe_stage_reg.sv
`timescale 1ns/1ps

module exe_stage_reg import exe_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  logic     clk,
    input  logic     rstn,
    exe_bus_if.sink  s0,
    input  logic     hazard,
    input  logic     wb_ready,
    exe_bus_if.src   s1,
    output logic     stall
);

    // issue may only advance when this register can move on
    assign stall = !wb_ready || hazard;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            s1.kind <= RES_NONE;
        end else if (wb_ready) begin
            // mul-use hazard leaves a bubble behind the multiply
            s1.kind <= hazard ? RES_NONE : s0.kind;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_ready) begin
            s1.rd <= s0.rd;
            s1.result <= s0.result;
            s1.mul_high <= s0.mul_high;
            s1.mul_unsigned <= s0.mul_unsigned;
            s1.pp0 <= s0.pp0;
            s1.pp1 <= s0.pp1;
            s1.pp2 <= s0.pp2;
            s1.pp3 <= s0.pp3;
        end
    end

    // the bubble clears a mul-use hazard after one cycle
    assert property (@(posedge clk) disable iff (!rstn)
        hazard && wb_ready |=> !hazard)
        else $error("mul-use hazard lasted more than one cycle");

endmodule

// File: hdl/exe_top.sv
`timescale 1ns/1ps

module exe_top import uop_pkg::*, exe_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              in_valid,
    input  logic [1:0]        uop_class,
    input  logic [3:0]        alu_op,
    input  logic [3:0]        br_cond,
    input  logic              mul_high,
    input  logic              mul_unsigned,
    input  logic              use_imm,
    input  logic [REG_AW-1:0] rd,
    input  logic [REG_AW-1:0] rj,
    input  logic [REG_AW-1:0] rk,
    input  logic [DATA_W-1:0] rf_data0,
    input  logic [DATA_W-1:0] rf_data1,
    input  logic [DATA_W-1:0] imm,
    input  logic [DATA_W-1:0] pc,
    input  logic [DATA_W-1:0] pc_next,
    input  logic              wb_ready,
    output logic              stall,
    output logic              br_valid,
    output logic              br_taken,
    output logic              br_mispredict,
    output logic [DATA_W-1:0] br_target,
    output logic              wb_en,
    output logic [REG_AW-1:0] wb_rd,
    output logic [DATA_W-1:0] wb_data
);

    uop_t uop;
    logic hazard;

    exe_bus_if #(.DATA_W(DATA_W)) s0_bus ();
    exe_bus_if #(.DATA_W(DATA_W)) s1_bus ();

    assign uop.cls = uop_class_e'(uop_class);
    assign uop.alu_op = alu_op_e'(alu_op);
    assign uop.br_cond = br_cond_e'(br_cond);
    assign uop.mul_high = mul_high;
    assign uop.mul_unsigned = mul_unsigned;
    assign uop.use_imm = use_imm;

    exe_issue #(.DATA_W(DATA_W)) issue_inst (
        .in_valid      (in_valid),
        .uop           (uop),
        .rd            (rd),
        .rj            (rj),
        .rk            (rk),
        .rf_data0      (rf_data0),
        .rf_data1      (rf_data1),
        .imm           (imm),
        .pc            (pc),
        .pc_next       (pc_next),
        .s1            (s1_bus.snoop),
        .wb_en         (wb_en),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .s0            (s0_bus.src),
        .hazard        (hazard),
        .br_valid      (br_valid),
        .br_taken      (br_taken),
        .br_mispredict (br_mispredict),
        .br_target     (br_target)
    );

    exe_stage_reg #(.DATA_W(DATA_W)) stage_reg_inst (
        .clk      (clk),
        .rstn     (rstn),
        .s0       (s0_bus.sink),
        .hazard   (hazard),
        .wb_ready (wb_ready),
        .s1       (s1_bus.src),
        .stall    (stall)
    );

    exe_retire #(.DATA_W(DATA_W)) retire_inst (
        .clk      (clk),
        .rstn     (rstn),
        .s1       (s1_bus.sink),
        .wb_ready (wb_ready),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

endmodule

// File: hdl/uop_pkg.sv
package uop_pkg;

    // execution unit the uop is steered to
    typedef enum logic [1:0] {
        UOP_ALU = 2'd0,
        UOP_BR  = 2'd1,
        UOP_MUL = 2'd2
    } uop_class_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    // same codes as the decoder's cond field
    typedef enum logic [3:0] {
        BR_JIRL = 4'd3,
        BR_B    = 4'd4,
        BR_BL   = 4'd5,
        BR_BEQ  = 4'd6,
        BR_BNE  = 4'd7,
        BR_BLT  = 4'd8,
        BR_BGE  = 4'd9,
        BR_BLTU = 4'd10,
        BR_BGEU = 4'd11
    } br_cond_e;

    typedef struct packed {
        uop_class_e cls;
        alu_op_e    alu_op;
        br_cond_e   br_cond;
        logic       mul_high;
        logic       mul_unsigned;
        logic       use_imm;
    } uop_t;

endpackage

// File: list.f
hdl/uop_pkg.sv
hdl/exe_pkg.sv
hdl/exe_bus_if.sv
hdl/exe_issue.sv
hdl/exe_stage_reg.sv
hdl/exe_retire.sv
hdl/exe_top.sv
sim/exe_tb.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module exe_tb -f list.f -o exe_sim \
    && ./obj_dir/exe_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "\*\* FAIL \*\*" sim.log && exit 1 || grep -q "\*\* PASS \*\*" sim.log || exit 1
exit 0

// File: sim/exe_stimulus.txt
# cls alu br mul_high mul_unsigned use_imm rd rj rk rf_data0 rf_data1 imm pc pc_next
# has_wb wb_rd wb_data taken mispredict target (all hex)
0 0 0 0 0 1 01 00 00 00000000 00000000 00000123 00000000 00000000 1 01 00000123 0 0 00000000
0 0 0 0 0 1 02 00 00 00000000 00000000 fffffff0 00000000 00000000 1 02 fffffff0 0 0 00000000
0 0 0 0 0 0 03 01 02 00000000 00000000 00000000 00000000 00000000 1 03 00000113 0 0 00000000
0 1 0 0 0 0 04 03 01 00000000 00000123 00000000 00000000 00000000 1 04 fffffff0 0 0 00000000
0 2 0 0 0 1 05 03 00 00000000 00000000 000000ff 00000000 00000000 1 05 00000013 0 0 00000000
0 3 0 0 0 0 06 01 02 00000123 fffffff0 00000000 00000000 00000000 1 06 fffffff3 0 0 00000000
0 4 0 0 0 1 07 02 00 fffffff0 00000000 0000ffff 00000000 00000000 1 07 ffff000f 0 0 00000000
0 5 0 0 0 1 08 01 00 00000123 00000000 00000004 00000000 00000000 1 08 00001230 0 0 00000000
0 6 0 0 0 0 09 02 05 fffffff0 00000013 00000000 00000000 00000000 1 09 00001fff 0 0 00000000
0 7 0 0 0 1 0a 02 00 fffffff0 00000000 00000004 00000000 00000000 1 0a ffffffff 0 0 00000000
0 8 0 0 0 0 0b 02 01 fffffff0 00000123 00000000 00000000 00000000 1 0b 00000001 0 0 00000000
0 9 0 0 0 0 0c 02 01 fffffff0 00000123 00000000 00000000 00000000 1 0c 00000000 0 0 00000000
0 0 0 0 0 1 00 01 00 00000123 00000000 00000001 00000000 00000000 0 00 00000000 0 0 00000000
0 8 0 0 0 1 0d 04 00 fffffff0 00000000 00000000 00000000 00000000 1 0d 00000001 0 0 00000000
2 0 0 0 0 0 0e 02 01 fffffff0 00000123 00000000 00000000 00000000 1 0e ffffedd0 0 0 00000000
0 0 0 0 0 1 0f 0e 00 00000000 00000000 00000001 00000000 00000000 1 0f ffffedd1 0 0 00000000
2 0 0 1 0 0 10 02 01 fffffff0 00000123 00000000 00000000 00000000 1 10 ffffffff 0 0 00000000
2 0 0 1 1 0 11 02 04 fffffff0 fffffff0 00000000 00000000 00000000 1 11 ffffffe0 0 0 00000000
2 0 0 0 1 0 12 01 11 00000123 00000000 00000000 00000000 00000000 1 12 ffffdba0 0 0 00000000
1 0 6 0 0 0 00 01 01 00000123 00000123 00000040 00001000 00001040 0 00 00000000 1 0 00001040
1 0 7 0 0 0 00 01 01 00000123 00000123 00000020 00001004 00001024 0 00 00000000 0 1 00001024
1 0 8 0 0 0 00 02 01 fffffff0 00000123 fffffff8 00001008 0000100c 0 00 00000000 1 1 00001000
1 0 9 0 0 0 00 02 01 fffffff0 00000123 00000010 0000100c 00001010 0 00 00000000 0 0 0000101c
1 0 a 0 0 0 00 02 01 fffffff0 00000123 00000008 00001010 00001014 0 00 00000000 0 0 00001018
1 0 b 0 0 0 00 02 01 fffffff0 00000123 00000100 00001014 00001114 0 00 00000000 1 0 00001114
1 0 4 0 0 0 00 00 00 00000000 00000000 00000200 00001018 0000101c 0 00 00000000 1 1 00001218
1 0 5 0 0 0 01 00 00 00000000 00000000 00000040 0000101c 0000105c 1 01 00001020 1 0 0000105c
1 0 3 0 0 0 13 01 00 00000123 00000000 00000010 00001020 00001024 1 13 00001024 1 1 00001030
1 0 6 0 0 0 00 13 01 00000000 00000000 00000008 00001024 00001028 0 00 00000000 0 0 0000102c
0 0 0 0 0 0 14 13 01 00000000 00001020 00000000 00000000 00000000 1 14 00002044 0 0 00000000

// File: sim/exe_tb.sv
`timescale 1ns/1ps

module exe_tb import uop_pkg::*, exe_pkg::*;;

    localparam int DATA_W = 32;
    localparam int STALL_LIMIT = 50;
    localparam int DRAIN_LIMIT = 200;

    logic              clk;
    logic              rstn;
    logic              in_valid;
    logic [1:0]        uop_class;
    logic [3:0]        alu_op;
    logic [3:0]        br_cond;
    logic              mul_high;
    logic              mul_unsigned;
    logic              use_imm;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rj;
    logic [REG_AW-1:0] rk;
    logic [DATA_W-1:0] rf_data0;
    logic [DATA_W-1:0] rf_data1;
    logic [DATA_W-1:0] imm;
    logic [DATA_W-1:0] pc;
    logic [DATA_W-1:0] pc_next;
    logic              wb_ready;
    logic              stall;
    logic              br_valid;
    logic              br_taken;
    logic              br_mispredict;
    logic [DATA_W-1:0] br_target;
    logic              wb_en;
    logic [REG_AW-1:0] wb_rd;
    logic [DATA_W-1:0] wb_data;

    logic [REG_AW-1:0] exp_rd_q[$];
    logic [DATA_W-1:0] exp_data_q[$];
    int                value_errors;
    int                proto_errors;
    int                timeouts;
    int                seed;
    logic              loaded;
    logic              last_en;
    logic [REG_AW-1:0] last_rd;
    logic [DATA_W-1:0] last_data;
    logic [REG_AW-1:0] mul_rd_prev;

    exe_top #(.DATA_W(DATA_W)) exe_top_inst (.*);

    always #5 clk = !clk;

    task automatic finish_run();
        $display("errors: %0d value, %0d protocol, %0d timeout",
                 value_errors, proto_errors, timeouts);
        if (value_errors + proto_errors + timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    task automatic check_wb(input logic [REG_AW-1:0] exp_rd, input logic [DATA_W-1:0] exp_data);
        if (wb_rd !== exp_rd || wb_data !== exp_data) begin
            value_errors++;
            $display("[ERROR] %0t writeback r%0d=%h, expected r%0d=%h",
                     $time, wb_rd, wb_data, exp_rd, exp_data);
        end
    endtask

    task automatic check_branch(input logic taken, input logic mispredict,
                                input logic [DATA_W-1:0] target);
        if (br_valid !== 1'b1 || br_taken !== taken || br_mispredict !== mispredict ||
            br_target !== target) begin
            value_errors++;
            $display("[ERROR] %0t branch v=%b t=%b m=%b tgt=%h, expected t=%b m=%b tgt=%h",
                     $time, br_valid, br_taken, br_mispredict, br_target,
                     taken, mispredict, target);
        end
    endtask

    // source registers a uop really reads, by class and branch kind
    function automatic logic reads_reg(input logic [31:0] f [20],
                                       input logic [REG_AW-1:0] r);
        logic rj_used;
        logic rk_used;
        rj_used = 1'b1;
        rk_used = 1'b1;
        if (f[0][1:0] == UOP_ALU) begin
            rk_used = !f[5][0];
        end else if (f[0][1:0] == UOP_BR) begin
            rj_used = f[2][3:0] != BR_B && f[2][3:0] != BR_BL;
            rk_used = f[2][3:0] != BR_B && f[2][3:0] != BR_BL && f[2][3:0] != BR_JIRL;
        end
        return (rj_used && f[7][REG_AW-1:0] == r) || (rk_used && f[8][REG_AW-1:0] == r);
    endfunction

    // present one uop and hold it until the stage accepts it
    task automatic issue_uop(input logic [31:0] f [20]);
        int   waited;
        int   hazard_cycles;
        logic dep;
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        uop_class = f[0][1:0];
        alu_op = f[1][3:0];
        br_cond = f[2][3:0];
        mul_high = f[3][0];
        mul_unsigned = f[4][0];
        use_imm = f[5][0];
        rd = f[6][REG_AW-1:0];
        rj = f[7][REG_AW-1:0];
        rk = f[8][REG_AW-1:0];
        rf_data0 = f[9];
        rf_data1 = f[10];
        imm = f[11];
        pc = f[12];
        pc_next = f[13];
        waited = 0;
        hazard_cycles = 0;
        dep = mul_rd_prev != '0 && reads_reg(f, mul_rd_prev);
        @(negedge clk);
        while (stall && waited < STALL_LIMIT) begin
            // with wb_ready high only a mul-use hazard stalls
            if (wb_ready) begin
                hazard_cycles++;
            end
            @(negedge clk);
            waited++;
        end
        if (stall) begin
            timeouts++;
            $display("timeout: uop at pc %h was never accepted, stall stayed high", f[12]);
        end else begin
            if (hazard_cycles != (dep ? 1 : 0)) begin
                value_errors++;
                $display("[ERROR] %0t uop to r%0d saw %0d hazard stall cycles, expected %0d",
                         $time, f[6][REG_AW-1:0], hazard_cycles, dep ? 1 : 0);
            end
            if (f[0][1:0] == UOP_BR) begin
                check_branch(f[17][0], f[18][0], f[19]);
            end else if (br_valid) begin
                value_errors++;
                $display("[ERROR] %0t br_valid high for a non-branch uop", $time);
            end
            if (f[14][0]) begin
                exp_rd_q.push_back(f[15][REG_AW-1:0]);
                exp_data_q.push_back(f[16]);
            end
            mul_rd_prev = (f[0][1:0] == UOP_MUL) ? f[6][REG_AW-1:0] : '0;
        end
    endtask

    // drop wb_ready about one cycle in four
    always @(posedge clk) begin
        if (rstn) begin
            #1 wb_ready = ($random(seed) & 3) != 0;
        end
    end

    always @(posedge clk) begin
        loaded <= rstn && wb_ready;
    end

    always @(negedge clk) begin
        if (rstn) begin
            if (!loaded) begin
                if (wb_en !== last_en || wb_rd !== last_rd || wb_data !== last_data) begin
                    proto_errors++;
                    $display("writeback outputs changed at %0t while wb_ready was low", $time);
                end
            end else if (wb_en) begin
                if (exp_rd_q.size() == 0) begin
                    proto_errors++;
                    $display("unexpected writeback to r%0d at %0t", wb_rd, $time);
                end else begin
                    check_wb(exp_rd_q.pop_front(), exp_data_q.pop_front());
                end
            end
            if (!wb_ready && !stall) begin
                proto_errors++;
                $display("stall was low at %0t although wb_ready was low", $time);
            end
        end
        last_en = wb_en;
        last_rd = wb_rd;
        last_data = wb_data;
    end

    initial begin
        int          fd;
        int          n;
        int          waited;
        string       line;
        logic [31:0] f [20];
        clk = 1'b0;
        rstn = 1'b0;
        in_valid = 1'b0;
        {uop_class, alu_op, br_cond, mul_high, mul_unsigned, use_imm} = '0;
        {rd, rj, rk} = '0;
        {rf_data0, rf_data1, imm, pc, pc_next} = '0;
        wb_ready = 1'b1;
        loaded = 1'b0;
        mul_rd_prev = '0;
        value_errors = 0;
        proto_errors = 0;
        timeouts = 0;
        seed = 32'hc1ec931b;
        repeat (10) @(posedge clk);
        #1 rstn = 1'b1;
        @(negedge clk);
        if (wb_en !== 1'b0 || br_valid !== 1'b0 || stall !== 1'b0) begin
            proto_errors++;
            $display("outputs not idle after reset: wb_en=%b br_valid=%b stall=%b",
                     wb_en, br_valid, stall);
        end
        fd = $fopen("sim/exe_stimulus.txt", "r");
        if (fd == 0) begin
            proto_errors++;
            $display("could not open the stimulus file sim/exe_stimulus.txt");
        end
        while (fd != 0 && !$feof(fd) && timeouts == 0) begin
            n = $fgets(line, fd);
            if (n > 1 && line.substr(0, 0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                            f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18],
                            f[19]);
                if (n == 20) begin
                    issue_uop(f);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        @(posedge clk);
        #1 in_valid = 1'b0;
        if (timeouts == 0) begin
            waited = 0;
            while (exp_rd_q.size() != 0 && waited < DRAIN_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (exp_rd_q.size() != 0) begin
                timeouts++;
                $display("timeout: %0d writebacks never arrived", exp_rd_q.size());
            end
        end
        // catch any extra writeback
        waited = 0;
        while (waited < 8) begin
            @(negedge clk);
            waited++;
        end
        finish_run();
    end

endmodule
